//--- verilog/ledkey_pkg.sv
// shared widths, address map, request structs and TM1638 commands, imported by every RTL block
`default_nettype none

package ledkey_pkg;

	typedef logic [7:0] byte_t;       // data byte on bus, ram and pin
	typedef logic [3:0] ram_addr_t;   // display ram byte index
	typedef logic [7:0] apb_addr_t;   // host byte address
	typedef logic [4:0] ser_count_t;  // bytes in one serial transfer

	// address map
	localparam apb_addr_t CTRL_ADDR  = 8'h10;  // above the 16 ram bytes
	localparam byte_t     CTRL_RESET = 8'h08;  // display on, lowest brightness

	// TM1638 commands
	localparam byte_t CMD_AUTO_INC = 8'h40;  // data write, auto increment
	localparam byte_t CMD_ADDR0    = 8'hC0;  // start at grid 0
	localparam byte_t CMD_DISPLAY  = 8'h80;  // or'ed with ctrl

	localparam int BATCH_BYTES = 17;  // address command plus 16 data bytes

	// one request to the single ram port
	typedef struct packed {
		logic      valid;
		logic      we;
		ram_addr_t addr;
		byte_t     wdata;
	} mem_req_t;

	// one transfer for the serializer, first byte at the top
	typedef struct packed {
		ser_count_t                  count;
		byte_t [BATCH_BYTES-1:0]     bytes;
	} ser_req_t;

endpackage

`default_nettype wire

//--- verilog/display_ram.sv
// 16-byte display RAM with registered read, cleared after reset before it takes requests
`default_nettype none
`timescale 1ns/100ps

module display_ram (
	input  wire                  i_clk,
	input  wire                  i_rst_n,
	input  ledkey_pkg::mem_req_t i_req,
	output ledkey_pkg::byte_t    o_rdata,
	output logic                 o_ready
);
	import ledkey_pkg::*;

	byte_t     mem [16];
	ram_addr_t clr_cnt;   // byte being cleared
	logic      clr_busy;  // clear sweep in progress

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			clr_cnt  <= '0;
			clr_busy <= 1'b1;
		end else if (clr_busy) begin
			clr_cnt <= clr_cnt + 4'd1;
			if (clr_cnt == 4'hF)
				clr_busy <= 1'b0;  // sweep done
		end
	end

	always_ff @(posedge i_clk) begin
		if (clr_busy)
			mem[clr_cnt] <= '0;
		else if (i_req.valid && i_req.we)
			mem[i_req.addr] <= i_req.wdata;
		o_rdata <= mem[i_req.addr];  // read always registered
	end

	assign o_ready = !clr_busy;

endmodule

`default_nettype wire

//--- verilog/ram_arbiter.sv
// round-robin arbiter sharing the single display RAM port between the host and the refresh engine
`default_nettype none
`timescale 1ns/100ps

module ram_arbiter (
	input  wire                  i_clk,
	input  wire                  i_rst_n,
	input  ledkey_pkg::mem_req_t i_host_req,
	input  ledkey_pkg::mem_req_t i_refr_req,
	output logic                 o_host_gnt,
	output logic                 o_refr_gnt,
	output logic                 o_host_rvalid,
	output logic                 o_refr_rvalid,
	output ledkey_pkg::mem_req_t o_ram_req,
	input  wire                  i_ram_ready
);
	import ledkey_pkg::*;

	logic last_refr;    // refresh won last, host goes next on a tie
	logic rd_pend;      // read data arrives this cycle
	logic rd_owner;     // 1 = refresh owns the pending read

	always_comb begin
		o_host_gnt = i_ram_ready && i_host_req.valid &&
			(!i_refr_req.valid || last_refr);
		o_refr_gnt = i_ram_ready && i_refr_req.valid && !o_host_gnt;
		if (o_host_gnt)
			o_ram_req = i_host_req;
		else if (o_refr_gnt)
			o_ram_req = i_refr_req;
		else
			o_ram_req = '0;  // idle port
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			last_refr <= 1'b1;  // host first after reset
			rd_pend   <= 1'b0;
			rd_owner  <= 1'b0;
		end else begin
			if (o_host_gnt || o_refr_gnt)
				last_refr <= o_refr_gnt;
			rd_pend  <= o_ram_req.valid && !o_ram_req.we;
			rd_owner <= o_refr_gnt;
		end
	end

	assign o_host_rvalid = rd_pend && !rd_owner;
	assign o_refr_rvalid = rd_pend && rd_owner;

endmodule

`default_nettype wire

//--- verilog/apb_ram_port.sv
// APB3 slave mapping the display RAM bytes and the control register, flags every completed write
`default_nettype none
`timescale 1ns/100ps

module apb_ram_port (
	input  wire                   i_clk,
	input  wire                   i_rst_n,
	input  wire                   i_psel,
	input  wire                   i_penable,
	input  wire                   i_pwrite,
	input  ledkey_pkg::apb_addr_t i_paddr,
	input  ledkey_pkg::byte_t     i_pwdata,
	output ledkey_pkg::byte_t     o_prdata,
	output logic                  o_pready,
	output logic                  o_pslverr,
	output ledkey_pkg::mem_req_t  o_mem_req,
	input  wire                   i_gnt,
	input  wire                   i_rvalid,
	input  ledkey_pkg::byte_t     i_rdata,
	output ledkey_pkg::byte_t     o_ctrl,
	output logic                  o_dirty
);
	import ledkey_pkg::*;

	logic  access;   // apb access phase
	logic  is_ram;
	logic  is_ctrl;
	logic  bad_addr;
	logic  rd_wait;  // read granted, data due
	byte_t ctrl_q;

	assign access   = i_psel && i_penable;
	assign is_ram   = (i_paddr[7:4] == 4'h0);
	assign is_ctrl  = (i_paddr == CTRL_ADDR);
	assign bad_addr = !is_ram && !is_ctrl;

	always_comb begin
		o_mem_req.valid = access && is_ram && !rd_wait;
		o_mem_req.we    = i_pwrite;
		o_mem_req.addr  = ram_addr_t'(i_paddr[3:0]);
		o_mem_req.wdata = i_pwdata;

		// ctrl and bad addresses finish at once, ram waits on the arbiter
		o_pready  = access && (!is_ram || (i_gnt && i_pwrite) || (rd_wait && i_rvalid));
		o_pslverr = access && bad_addr;

		if (is_ctrl)
			o_prdata = ctrl_q;
		else if (is_ram)
			o_prdata = i_rdata;
		else
			o_prdata = '0;
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			rd_wait <= 1'b0;
			ctrl_q  <= CTRL_RESET;
			o_dirty <= 1'b0;
		end else begin
			if (i_gnt && !i_pwrite)
				rd_wait <= 1'b1;
			else if (i_rvalid)
				rd_wait <= 1'b0;  // data returned
			if (access && i_pwrite && is_ctrl)
				ctrl_q <= i_pwdata;
			o_dirty <= o_pready && i_pwrite && !bad_addr;  // one pulse per write
		end
	end

	assign o_ctrl = ctrl_q;

endmodule

`default_nettype wire

//--- verilog/ledkey_refresh.sv
// frame sequencer: on a pending change fetches the RAM, builds the batch and issues the three transfers
`default_nettype none
`timescale 1ns/100ps

module ledkey_refresh (
	input  wire                  i_clk,
	input  wire                  i_rst_n,
	input  wire                  i_dirty,
	input  ledkey_pkg::byte_t    i_ctrl,
	output ledkey_pkg::mem_req_t o_mem_req,
	input  wire                  i_gnt,
	input  wire                  i_rvalid,
	input  ledkey_pkg::byte_t    i_rdata,
	output ledkey_pkg::ser_req_t o_ser_req,
	output logic                 o_ser_valid,
	input  wire                  i_ser_ready
);
	import ledkey_pkg::*;

	typedef enum logic [2:0] {
		IDLE,
		SEND_MODE,
		FETCH,
		WAIT_MEM,
		FILL,
		SEND_BATCH,
		SEND_DISPLAY
	} state_t;

	state_t              state;
	logic                pending;   // a frame is owed
	logic                start;
	ram_addr_t           idx;       // ram byte being fetched
	byte_t               rd_byte;
	byte_t               disp_cmd;  // display command, ctrl sampled
	byte_t [15:0]        batch;     // data slots 1..16
	logic  [4:0]         slot;

	assign start = (state == IDLE) && pending;

	// seg n goes to slot 2n+1, led n to slot 2n+2
	always_comb begin
		if (idx[3])
			slot = {1'b0, idx[2:0], 1'b0} + 5'd2;
		else
			slot = {1'b0, idx[2:0], 1'b0} + 5'd1;
	end

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state   <= IDLE;
			pending <= 1'b1;  // first frame after reset
			idx     <= '0;
		end else begin
			pending <= i_dirty || (pending && !start);
			case (state)
				IDLE: if (pending) state <= SEND_MODE;
				SEND_MODE: begin
					if (i_ser_ready) begin
						idx   <= '0;
						state <= FETCH;
					end
				end
				FETCH: if (i_gnt) state <= WAIT_MEM;
				WAIT_MEM: if (i_rvalid) state <= FILL;
				FILL: begin
					idx   <= idx + 4'd1;
					state <= (idx == 4'hF) ? SEND_BATCH : FETCH;
				end
				SEND_BATCH: if (i_ser_ready) state <= SEND_DISPLAY;
				SEND_DISPLAY: if (i_ser_ready) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == WAIT_MEM && i_rvalid)
			rd_byte <= i_rdata;
		if (state == FILL)
			batch[16 - slot] <= rd_byte;
		if (state == SEND_BATCH && i_ser_ready)
			disp_cmd <= CMD_DISPLAY | i_ctrl;  // latest ctrl value
	end

	always_comb begin
		o_mem_req.valid = (state == FETCH);
		o_mem_req.we    = 1'b0;
		o_mem_req.addr  = idx;
		o_mem_req.wdata = '0;

		o_ser_valid     = (state == SEND_MODE) || (state == SEND_BATCH) ||
			(state == SEND_DISPLAY);
		o_ser_req.count = ser_count_t'(1);
		o_ser_req.bytes = '0;
		case (state)
			SEND_BATCH: begin
				o_ser_req.count = ser_count_t'(BATCH_BYTES);
				o_ser_req.bytes = {CMD_ADDR0, batch};
			end
			SEND_DISPLAY: o_ser_req.bytes[BATCH_BYTES-1] = disp_cmd;
			default:      o_ser_req.bytes[BATCH_BYTES-1] = CMD_AUTO_INC;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/tm1638_serial.sv
// TM1638 bit serializer: sends 1 to 17 bytes LSB first under one strobe low window
`default_nettype none
`timescale 1ns/100ps

module tm1638_serial #(
	parameter int CLK_DIV = 4
) (
	input  wire                  i_clk,
	input  wire                  i_rst_n,
	input  ledkey_pkg::ser_req_t i_req,
	input  wire                  i_valid,
	output logic                 o_ready,
	output logic                 o_busy,
	output logic                 o_tm1638_clk,
	output logic                 o_tm1638_stb,
	output logic                 o_tm1638_dio
);
	import ledkey_pkg::*;

	localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

	typedef enum logic [2:0] {
		S_IDLE,
		S_START,
		S_LOW,
		S_HIGH,
		S_STOP,
		S_HOLD
	} state_t;

	state_t                  state;
	logic [DIV_W-1:0]        div_cnt;
	logic                    div_end;   // half period elapsed
	logic [2:0]              bit_cnt;
	ser_count_t              left;      // bytes still to send
	byte_t [BATCH_BYTES-1:0] data_q;    // current byte at the top
	logic                    byte_end;

	assign div_end  = (div_cnt == DIV_W'(CLK_DIV - 1));
	assign byte_end = (state == S_HIGH) && div_end && (bit_cnt == 3'd7);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			state        <= S_IDLE;
			div_cnt      <= '0;
			bit_cnt      <= '0;
			left         <= '0;
			o_tm1638_clk <= 1'b1;
			o_tm1638_stb <= 1'b1;
			o_tm1638_dio <= 1'b1;
		end else begin
			if (state == S_IDLE || div_end)
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
			case (state)
				S_IDLE: begin
					if (i_valid) begin
						left         <= i_req.count;
						o_tm1638_stb <= 1'b0;
						state        <= S_START;
					end
				end
				S_START: begin
					if (div_end) begin
						bit_cnt      <= '0;
						o_tm1638_clk <= 1'b0;
						o_tm1638_dio <= data_q[BATCH_BYTES-1][0];
						state        <= S_LOW;
					end
				end
				S_LOW: begin
					if (div_end) begin
						o_tm1638_clk <= 1'b1;  // board samples here
						state        <= S_HIGH;
					end
				end
				S_HIGH: begin
					if (div_end) begin
						if (bit_cnt == 3'd7 && left == ser_count_t'(1)) begin
							state <= S_STOP;  // last bit out
						end else begin
							bit_cnt      <= bit_cnt + 3'd1;
							o_tm1638_clk <= 1'b0;
							state        <= S_LOW;
							if (bit_cnt == 3'd7) begin
								left         <= left - 1'b1;
								o_tm1638_dio <= data_q[BATCH_BYTES-2][0];
							end else begin
								o_tm1638_dio <= data_q[BATCH_BYTES-1][bit_cnt + 3'd1];
							end
						end
					end
				end
				S_STOP: begin
					if (div_end) begin
						o_tm1638_stb <= 1'b1;
						state        <= S_HOLD;
					end
				end
				S_HOLD: if (div_end) state <= S_IDLE;  // stb high time
				default: state <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (state == S_IDLE && i_valid)
			data_q <= i_req.bytes;
		else if (byte_end)
			data_q <= {data_q[BATCH_BYTES-2:0], 8'h00};  // next byte to top
	end

	assign o_ready = (state == S_IDLE);
	assign o_busy  = (state != S_IDLE);

endmodule

`default_nettype wire

//--- verilog/ledkey_top.sv
// LED&KEY driver top level: APB port, RAM arbiter, display RAM, refresh engine and serializer
`default_nettype none
`timescale 1ns/100ps

module ledkey_top #(
	parameter int CLK_DIV = 4
) (
	input  wire                   i_clk,
	input  wire                   i_rst_n,
	input  wire                   i_psel,
	input  wire                   i_penable,
	input  wire                   i_pwrite,
	input  ledkey_pkg::apb_addr_t i_paddr,
	input  ledkey_pkg::byte_t     i_pwdata,
	output ledkey_pkg::byte_t     o_prdata,
	output logic                  o_pready,
	output logic                  o_pslverr,
	output logic                  o_tm1638_clk,
	output logic                  o_tm1638_stb,
	output logic                  o_tm1638_dio
);
	import ledkey_pkg::*;

	mem_req_t host_req;
	mem_req_t refr_req;
	mem_req_t ram_req;
	logic     host_gnt;
	logic     refr_gnt;
	logic     host_rvalid;
	logic     refr_rvalid;
	logic     ram_ready;
	byte_t    ram_rdata;
	byte_t    ctrl;
	logic     dirty;
	ser_req_t ser_req;
	logic     ser_valid;
	logic     ser_ready;

	apb_ram_port u_apb (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_psel    (i_psel),
		.i_penable (i_penable),
		.i_pwrite  (i_pwrite),
		.i_paddr   (i_paddr),
		.i_pwdata  (i_pwdata),
		.o_prdata  (o_prdata),
		.o_pready  (o_pready),
		.o_pslverr (o_pslverr),
		.o_mem_req (host_req),
		.i_gnt     (host_gnt),
		.i_rvalid  (host_rvalid),
		.i_rdata   (ram_rdata),
		.o_ctrl    (ctrl),
		.o_dirty   (dirty)
	);

	ram_arbiter u_arb (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_host_req    (host_req),
		.i_refr_req    (refr_req),
		.o_host_gnt    (host_gnt),
		.o_refr_gnt    (refr_gnt),
		.o_host_rvalid (host_rvalid),
		.o_refr_rvalid (refr_rvalid),
		.o_ram_req     (ram_req),
		.i_ram_ready   (ram_ready)
	);

	display_ram u_ram (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_req   (ram_req),
		.o_rdata (ram_rdata),
		.o_ready (ram_ready)
	);

	ledkey_refresh u_refresh (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_dirty     (dirty),
		.i_ctrl      (ctrl),
		.o_mem_req   (refr_req),
		.i_gnt       (refr_gnt),
		.i_rvalid    (refr_rvalid),
		.i_rdata     (ram_rdata),
		.o_ser_req   (ser_req),
		.o_ser_valid (ser_valid),
		.i_ser_ready (ser_ready)
	);

	tm1638_serial #(
		.CLK_DIV (CLK_DIV)
	) u_serial (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_req        (ser_req),
		.i_valid      (ser_valid),
		.o_ready      (ser_ready),
		.o_busy       (),
		.o_tm1638_clk (o_tm1638_clk),
		.o_tm1638_stb (o_tm1638_stb),
		.o_tm1638_dio (o_tm1638_dio)
	);

endmodule

`default_nettype wire

//--- bench/tm1638_monitor.sv
// bench monitor: rebuilds TM1638 transfers from the board pins, one byte list per strobe window
`default_nettype none
`timescale 1ns/100ps

module tm1638_monitor (
	input wire i_tm1638_clk,
	input wire i_tm1638_stb,
	input wire i_tm1638_dio
);
	localparam int MAX_BYTES = 17;

	logic [8*MAX_BYTES-1:0] xfer_data [$];     // byte 0 in the low bits
	int                     xfer_len  [$];     // bytes per transfer
	int                     xfer_total = 0;    // strobe windows seen
	int                     bad_xfers  = 0;    // partial byte or too long
	logic [8*MAX_BYTES-1:0] shift      = '0;
	int                     nbits      = 0;

	// a rising stb closes the window, a rising clk with stb low is one data bit
	always @(posedge i_tm1638_clk or posedge i_tm1638_stb) begin
		if (i_tm1638_stb === 1'b1) begin
			if (nbits > 0) begin
				xfer_total++;
				if (nbits % 8 != 0 || nbits > 8*MAX_BYTES) begin
					bad_xfers++;
				end else begin
					xfer_data.push_back(shift);
					xfer_len.push_back(nbits / 8);
				end
				nbits = 0;
				shift = '0;
			end
		end else if (i_tm1638_stb === 1'b0) begin
			if (nbits < 8*MAX_BYTES)
				shift[nbits] = i_tm1638_dio;  // lsb first
			nbits++;
		end
	end

endmodule

`default_nettype wire

//--- bench/tb_ledkey_top.sv
// testbench for the LED&KEY driver: LFSR driven APB traffic, board frames checked against a model
`default_nettype none
`timescale 1ns/100ps

module tb_ledkey_top;
	localparam int CLK_DIV      = 2;
	localparam int N_FRAMES     = 20;                        // upper bound for the whole run
	localparam int FRAME_NS     = 17 * 16 * CLK_DIV * 10;
	localparam int WATCHDOG_NS  = N_FRAMES * FRAME_NS + 60000;
	localparam int QUIET_CYCLES = 200;                       // longer than any gap in a frame
	localparam int APB_LIMIT    = 2000;
	localparam logic [7:0] REG_CTRL = 8'h10;

	logic        clk = 1'b0;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [7:0]  paddr;
	logic [7:0]  pwdata;
	logic [7:0]  prdata;
	logic        pready;
	logic        pslverr;
	logic        tm_clk;
	logic        tm_stb;
	logic        tm_dio;
	logic [31:0] lfsr = 32'h2754666d;
	logic [7:0]  model_ram [16];
	logic [7:0]  model_ctrl;
	int          n_checks = 0;
	int          n_errors = 0;
	int          n_tests = 0;
	int          n_failed = 0;
	int          test_base = 0;  // errors before the current test

	always #5 clk = ~clk;

	ledkey_top #(
		.CLK_DIV (CLK_DIV)
	) i_dut (
		.i_clk        (clk),
		.i_rst_n      (rst_n),
		.i_psel       (psel),
		.i_penable    (penable),
		.i_pwrite     (pwrite),
		.i_paddr      (paddr),
		.i_pwdata     (pwdata),
		.o_prdata     (prdata),
		.o_pready     (pready),
		.o_pslverr    (pslverr),
		.o_tm1638_clk (tm_clk),
		.o_tm1638_stb (tm_stb),
		.o_tm1638_dio (tm_dio)
	);

	tm1638_monitor u_mon (
		.i_tm1638_clk (tm_clk),
		.i_tm1638_stb (tm_stb),
		.i_tm1638_dio (tm_dio)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);  // x^32+x^22+x^2+x+1
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			n_errors++;
			$display("Fail at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
		end
	endtask

	task automatic apb_access(input logic wr, input logic [7:0] addr, input logic [7:0] wdata,
			output logic [7:0] rdata, output logic err);
		int   waited;
		logic done;
		waited = 0;
		done = 1'b0;
		rdata = '0;
		err = 1'b0;
		@(posedge clk);
		psel    <= 1'b1;  // setup phase
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		while (!done && waited < APB_LIMIT) begin
			@(negedge clk);
			if (pready === 1'b1) begin
				rdata = prdata;
				err = pslverr;
				done = 1'b1;
			end else begin
				waited++;
			end
			@(posedge clk);
		end
		psel    <= 1'b0;
		penable <= 1'b0;
		if (!done) begin
			n_errors++;
			$display("APB %s at 0x%02h never got pready", wr ? "write" : "read", addr);
		end
	endtask

	task automatic apb_write(input logic [7:0] addr, input logic [7:0] data, input logic exp_err);
		logic [7:0] rd;
		logic       err;
		apb_access(1'b1, addr, data, rd, err);
		check_val($sformatf("pslverr write 0x%02h", addr), err, exp_err);
	endtask

	task automatic apb_read(input logic [7:0] addr, input logic [7:0] exp, input logic exp_err);
		logic [7:0] rd;
		logic       err;
		apb_access(1'b0, addr, 8'h00, rd, err);
		check_val($sformatf("pslverr read 0x%02h", addr), err, exp_err);
		if (!exp_err)
			check_val($sformatf("prdata 0x%02h", addr), rd, exp);
	endtask

	// wait for a whole frame beyond start_total and then a quiet bus
	task automatic wait_frame_settle(input int start_total);
		int quiet;
		int last;
		quiet = 0;
		last = u_mon.xfer_total;
		while (!(quiet >= QUIET_CYCLES && u_mon.xfer_total > start_total &&
				u_mon.xfer_total % 3 == 0)) begin
			@(negedge clk);
			if (tm_stb !== 1'b1 || u_mon.xfer_total != last)
				quiet = 0;
			else
				quiet++;
			last = u_mon.xfer_total;
		end
	endtask

	task automatic check_frame(input string tag);
		int           n;
		int           k;
		logic [135:0] d;
		n = u_mon.xfer_len.size();
		if (n < 3) begin
			n_errors++;
			$display("%s: fewer than three transfers received, no frame to check", tag);
		end else begin
			check_val({tag, " mode length"}, u_mon.xfer_len[n-3], 1);
			d = u_mon.xfer_data[n-3];
			check_val({tag, " mode command"}, d[7:0], 8'h40);
			check_val({tag, " batch length"}, u_mon.xfer_len[n-2], 17);
			d = u_mon.xfer_data[n-2];
			check_val({tag, " address command"}, d[7:0], 8'hC0);
			for (k = 0; k < 8; k++) begin
				check_val($sformatf("%s seg%0d", tag, k), d[8*(2*k+1) +: 8], model_ram[k]);
				check_val($sformatf("%s led%0d", tag, k), d[8*(2*k+2) +: 8], model_ram[8+k]);
			end
			check_val({tag, " display length"}, u_mon.xfer_len[n-1], 1);
			d = u_mon.xfer_data[n-1];
			check_val({tag, " display command"}, d[7:0], 8'h80 | model_ctrl);
		end
	endtask

	task automatic end_test(input string name);
		n_tests++;
		if (n_errors == test_base) begin
			$display("test %0d %s: passed", n_tests, name);
		end else begin
			n_failed++;
			$display("test %0d %s: failed with %0d errors", n_tests, name, n_errors - test_base);
		end
		test_base = n_errors;
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: an expected frame never arrived on the board pins");
		$display("** FAIL **");
		$finish;
	end

	initial begin
		int          i;
		int          start;
		int          waited;
		logic [31:0] a;
		logic [31:0] r;
		rst_n   = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = 8'h00;
		pwdata  = 8'h00;
		for (i = 0; i < 16; i++)
			model_ram[i] = 8'h00;  // ram clears after reset
		model_ctrl = 8'h08;        // display on
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;

		wait_frame_settle(0);
		check_val("transfers after reset", u_mon.xfer_total, 3);
		check_frame("reset frame");
		end_test("reset frame");

		for (i = 0; i < 16; i++) begin
			rand_bits(8, r);
			apb_write(i[7:0], r[7:0], 1'b0);
			model_ram[i] = r[7:0];
		end
		for (i = 0; i < 16; i++) begin
			rand_bits(4, a);
			rand_bits(8, r);
			apb_write({4'h0, a[3:0]}, r[7:0], 1'b0);
			model_ram[a[3:0]] = r[7:0];
		end
		start = u_mon.xfer_total;
		for (i = 0; i < 16; i++)
			apb_read(i[7:0], model_ram[i], 1'b0);
		end_test("ram write and readback");

		wait_frame_settle(start);
		check_frame("frame after writes");
		end_test("frame after writes");

		rand_bits(8, r);
		apb_write(REG_CTRL, r[7:0], 1'b0);
		model_ctrl = r[7:0];
		start = u_mon.xfer_total;
		apb_read(REG_CTRL, model_ctrl, 1'b0);
		wait_frame_settle(start);
		check_frame("frame after ctrl write");
		end_test("control register");

		rand_bits(8, a);
		if (a[7:0] <= 8'h10)
			a[7:0] = a[7:0] | 8'h20;  // past the control register
		rand_bits(8, r);
		start = u_mon.xfer_total;
		apb_write(a[7:0], r[7:0], 1'b1);
		apb_read(a[7:0], 8'h00, 1'b1);
		repeat (QUIET_CYCLES) @(posedge clk);
		check_val("transfers after bad access", u_mon.xfer_total, start);
		for (i = 0; i < 16; i++)
			apb_read(i[7:0], model_ram[i], 1'b0);
		apb_read(REG_CTRL, model_ctrl, 1'b0);
		apb_write(REG_CTRL, model_ctrl, 1'b0);  // same value, just forces a frame
		wait_frame_settle(start);
		check_frame("frame after bad access");
		end_test("bad address");

		rand_bits(4, a);
		rand_bits(8, r);
		apb_write({4'h0, a[3:0]}, r[7:0], 1'b0);
		model_ram[a[3:0]] = r[7:0];
		waited = 0;
		while (tm_stb !== 1'b0 && waited < 100) begin
			@(negedge clk);
			waited++;
		end
		if (tm_stb !== 1'b0) begin
			n_errors++;
			$display("no frame started after a display write");
		end
		for (i = 0; i < 24; i++) begin
			rand_bits(5, a);
			if (a[4:0] > 5'd16)
				a[4] = 1'b0;
			rand_bits(8, r);
			apb_write({3'b000, a[4:0]}, r[7:0], 1'b0);
			if (a[4:0] == 5'd16)
				model_ctrl = r[7:0];
			else
				model_ram[a[3:0]] = r[7:0];
		end
		start = u_mon.xfer_total;
		wait_frame_settle(start);
		check_frame("frame after burst");
		if (u_mon.bad_xfers != 0) begin
			n_errors++;
			$display("board pins carried %0d transfers with a partial byte", u_mon.bad_xfers);
		end
		end_test("burst during frame");

		$display("tests run %0d, failed %0d, checks %0d, errors %0d",
			n_tests, n_failed, n_checks, n_errors);
		if (n_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- ledkey_top.f
verilog/ledkey_pkg.sv
verilog/display_ram.sv
verilog/ram_arbiter.sv
verilog/apb_ram_port.sv
verilog/ledkey_refresh.sv
verilog/tm1638_serial.sv
verilog/ledkey_top.sv
bench/tm1638_monitor.sv
bench/tb_ledkey_top.sv

//--- Bender.yml
package:
  name: ledkey_top

sources:
  - files:
      - verilog/ledkey_pkg.sv
      - verilog/display_ram.sv
      - verilog/ram_arbiter.sv
      - verilog/apb_ram_port.sv
      - verilog/ledkey_refresh.sv
      - verilog/tm1638_serial.sv
      - verilog/ledkey_top.sv
  - target: simulation
    files:
      - bench/tm1638_monitor.sv
      - bench/tb_ledkey_top.sv
